/* common/rvIsaPkg.sv */
// Only RV32I integer and M-extension encodings are defined, with no compressed or system forms
`default_nettype none

package rvIsaPkg;

   localparam int XLEN = 32;                           // Data and address width

   // Major opcodes, instruction bits [6:0]
   localparam logic [6:0] OpAluImm = 7'b0010011;       // ADDI, SLTI, ANDI, shifts by shamt
   localparam logic [6:0] OpAluReg = 7'b0110011;       // Register ALU ops and M extension
   localparam logic [6:0] OpLui    = 7'b0110111;
   localparam logic [6:0] OpAuipc  = 7'b0010111;
   localparam logic [6:0] OpJal    = 7'b1101111;
   localparam logic [6:0] OpJalr   = 7'b1100111;
   localparam logic [6:0] OpBranch = 7'b1100011;

   // ALU funct3
   localparam logic [2:0] F3Add  = 3'b000;             // ADD, SUB, ADDI
   localparam logic [2:0] F3Sll  = 3'b001;
   localparam logic [2:0] F3Slt  = 3'b010;
   localparam logic [2:0] F3Sltu = 3'b011;
   localparam logic [2:0] F3Xor  = 3'b100;
   localparam logic [2:0] F3Srl  = 3'b101;             // SRL and SRA, bit 30 picks SRA
   localparam logic [2:0] F3Or   = 3'b110;
   localparam logic [2:0] F3And  = 3'b111;

   // Branch funct3
   localparam logic [2:0] F3Beq  = 3'b000;
   localparam logic [2:0] F3Bne  = 3'b001;
   localparam logic [2:0] F3Blt  = 3'b100;
   localparam logic [2:0] F3Bge  = 3'b101;
   localparam logic [2:0] F3Bltu = 3'b110;
   localparam logic [2:0] F3Bgeu = 3'b111;

   // M-extension funct3, bit 2 splits multiply from divide
   localparam logic [2:0] F3Mul    = 3'b000;           // Low word
   localparam logic [2:0] F3Mulh   = 3'b001;           // High word, signed x signed
   localparam logic [2:0] F3Mulhsu = 3'b010;           // High word, signed x unsigned
   localparam logic [2:0] F3Mulhu  = 3'b011;           // High word, unsigned x unsigned
   localparam logic [2:0] F3Div    = 3'b100;
   localparam logic [2:0] F3Divu   = 3'b101;
   localparam logic [2:0] F3Rem    = 3'b110;
   localparam logic [2:0] F3Remu   = 3'b111;

   localparam logic [6:0] FunctM = 7'b0000001;         // funct7 of MUL/DIV family

   // Overlay of the 32-bit instruction word, MSB first
   typedef struct packed {
      logic [6:0] funct7;                              // Bit 5 is instruction bit 30
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } instrFields;

endpackage

`default_nettype wire

/* common/execPkg.sv */
// Layouts assume the fixed 32-bit datapath, and DivSteps must fit the divider's 6-bit counter
`default_nettype none

package execPkg;

   // One execute request, 128 bits
   typedef struct packed {
      logic [rvIsaPkg::XLEN-1:0] pc;
      rvIsaPkg::instrFields      instr;
      logic [rvIsaPkg::XLEN-1:0] rs1Val;                // Source operand values
      logic [rvIsaPkg::XLEN-1:0] rs2Val;
   } execReq;

   // One execute response, 64 bits
   typedef struct packed {
      logic [rvIsaPkg::XLEN-1:0] result;                // Destination value, 0 when none
      logic [rvIsaPkg::XLEN-1:0] nextPc;
   } execRsp;

   // Comparison results of rs1 against the second operand
   typedef struct packed {
      logic lt;                                        // Signed less-than
      logic ltu;                                       // Unsigned less-than
      logic eq;
   } aluFlags;

   // Handshake FSM
   typedef enum logic [1:0] {
      Idle = 2'd0,                                     // Waiting for req
      Wait = 2'd1,                                     // Computing
      Hold = 2'd2                                      // ack high until req drops
   } ctrlState;

   // 32 shift steps plus one output cycle
   localparam int DivSteps = 33;

endpackage

`default_nettype wire

/* rtl/immDecode.sv */
// Stores are not executed here, so the S format only serves opcodes whose result is discarded
`timescale 1ns/1ps
`default_nettype none

module immDecode (
   input  rvIsaPkg::instrFields instr,
   output logic [31:0]          imm
);

   import rvIsaPkg::*;

   logic        sgn;
   logic [31:0] iImm;
   logic [31:0] sImm;
   logic [31:0] bImm;
   logic [31:0] uImm;
   logic [31:0] jImm;

   assign sgn = instr.funct7[6];                       // Instruction bit 31, sign of every format

   // The five formats, built straight from the field overlay
   assign iImm = {{21{sgn}}, instr.funct7[5:0], instr.rs2};
   assign sImm = {{21{sgn}}, instr.funct7[5:0], instr.rd};
   assign bImm = {{20{sgn}}, instr.rd[0], instr.funct7[5:0], instr.rd[4:1], 1'b0};
   assign uImm = {instr.funct7, instr.rs2, instr.rs1, instr.funct3, 12'd0};
   assign jImm = {{12{sgn}}, instr.rs1, instr.funct3, instr.rs2[0], instr.funct7[5:0],
                  instr.rs2[4:1], 1'b0};

   // Format choice by opcode
   always_comb begin
      case (instr.opcode)
         OpAluImm, OpJalr: imm = iImm;                 // JALR adds I imm to rs1
         OpBranch:         imm = bImm;
         OpLui, OpAuipc:   imm = uImm;
         OpJal:            imm = jImm;
         default:          imm = sImm;                 // Store layout, also unknown opcodes
      endcase
   end

endmodule

`default_nettype wire

/* rtl/intAlu.sv */
// Combinational only, M-extension encodings pass through here but their aluOut is not used
`timescale 1ns/1ps
`default_nettype none

module intAlu (
   input  rvIsaPkg::instrFields instr,
   input  logic [31:0]          rs1Val,
   input  logic [31:0]          rs2Val,
   input  logic [31:0]          imm,
   output logic [31:0]          aluOut,
   output logic [31:0]          aluSum,
   output execPkg::aluFlags     flags
);

   import rvIsaPkg::*;

   logic [31:0] in2;                                   // Second operand
   logic [32:0] diff;                                  // rs1 - in2 with borrow in bit 32
   logic        lt;
   logic        isSub;
   logic        isSra;
   logic [31:0] shIn;
   logic [32:0] shifted;                               // Bit 32 is the fill bit

   // Bit reversal so one right shifter also does left shifts
   function automatic logic [31:0] flip(input logic [31:0] x);
      logic [31:0] y;
      for (int i = 0; i < 32; i++) begin
         y[i] = x[31 - i];
      end
      return y;
   endfunction

   // rs2 for register forms and branches, immediate otherwise
   assign in2 = ((instr.opcode == OpAluReg) || (instr.opcode == OpBranch)) ? rs2Val : imm;

   assign aluSum = rs1Val + in2;                       // Also the JALR target
   assign diff   = {1'b0, rs1Val} - {1'b0, in2};       // One subtractor for SUB and compares

   // Signs differ, so rs1 sign alone decides
   assign lt = (rs1Val[31] ^ in2[31]) ? rs1Val[31] : diff[32];
   assign flags = '{lt: lt, ltu: diff[32], eq: (diff[31:0] == 32'd0)};

   // Bit 30 marks SUB only for register forms, ADDI keeps immediate bits there
   assign isSub = (instr.opcode == OpAluReg) && instr.funct7[5];
   assign isSra = (instr.funct3 == F3Srl) && instr.funct7[5];

   assign shIn    = (instr.funct3 == F3Sll) ? flip(rs1Val) : rs1Val;
   assign shifted = $signed({isSra & rs1Val[31], shIn}) >>> in2[4:0];

   always_comb begin
      case (instr.funct3)
         F3Add:   aluOut = isSub ? diff[31:0] : aluSum;
         F3Sll:   aluOut = flip(shifted[31:0]);        // Undo the reversal
         F3Slt:   aluOut = {31'd0, lt};
         F3Sltu:  aluOut = {31'd0, diff[32]};
         F3Xor:   aluOut = rs1Val ^ in2;
         F3Srl:   aluOut = shifted[31:0];              // SRL or SRA by fill bit
         F3Or:    aluOut = rs1Val | in2;
         default: aluOut = rs1Val & in2;               // F3And
      endcase
   end

endmodule

`default_nettype wire

/* muldiv/mulUnit.sv */
// Operands and funct3 must be valid in the mulStart cycle, the product word is held until next start
`timescale 1ns/1ps
`default_nettype none

module mulUnit (
   input  logic        clk,
   input  logic        mulStart,
   input  logic [2:0]  funct3,
   input  logic [31:0] rs1Val,
   input  logic [31:0] rs2Val,
   output logic [31:0] mulResult
);

   import rvIsaPkg::*;

   logic               sign1;
   logic               sign2;
   logic signed [32:0] op1;
   logic signed [32:0] op2;
   logic signed [65:0] product;

   // Extension bits per variant, MUL low word does not depend on them
   assign sign1 = rs1Val[31] & ((funct3 == F3Mulh) || (funct3 == F3Mulhsu));
   assign sign2 = rs2Val[31] & (funct3 == F3Mulh);

   assign op1     = {sign1, rs1Val};
   assign op2     = {sign2, rs2Val};
   assign product = 66'(op1) * 66'(op2);               // One signed 33x33 multiplier

   always_ff @(posedge clk) begin
      if (mulStart) begin
         mulResult <= (funct3 == F3Mul) ? product[31:0] : product[63:32];
      end
   end

endmodule

`default_nettype wire

/* muldiv/divUnit.sv */
// Every operation takes DivSteps cycles after divStart, and a start while busy is ignored
`timescale 1ns/1ps
`default_nettype none

module divUnit (
   input  logic        clk,
   input  logic        reset,
   input  logic        divStart,
   input  logic [2:0]  funct3,
   input  logic [31:0] rs1Val,
   input  logic [31:0] rs2Val,
   output logic        divBusy,
   output logic [31:0] divResult
);

   import rvIsaPkg::*;
   import execPkg::*;

   logic        isSigned;
   logic        isRem;
   logic        startSign;
   logic        accept;
   logic [31:0] absA;
   logic [31:0] absB;
   logic [5:0]  cnt;                                   // Remaining cycles, 0 when idle
   logic [31:0] dividend;                              // Running remainder
   logic [62:0] divisor;                               // Aligned divisor, shifts right
   logic [31:0] quotient;
   logic        negate;                                // Result sign
   logic        remMode;

   assign isSigned = (funct3 == F3Div) || (funct3 == F3Rem);
   assign isRem    = (funct3 == F3Rem) || (funct3 == F3Remu);

   assign absA = (isSigned && rs1Val[31]) ? -rs1Val : rs1Val;
   assign absB = (isSigned && rs2Val[31]) ? -rs2Val : rs2Val;

   // Remainder takes dividend sign
   // Quotient sign is cleared for a zero divisor so the all-ones quotient stays -1
   assign startSign = isSigned && (isRem ? rs1Val[31] :
                                   ((rs1Val[31] != rs2Val[31]) && (rs2Val != 32'd0)));

   assign divBusy = (cnt != 6'd0);
   assign accept  = divStart && !divBusy;

   always_ff @(posedge clk) begin
      if (!reset) begin
         cnt <= '0;
      end else if (accept) begin
         cnt <= 6'(DivSteps);
      end else if (divBusy) begin
         cnt <= cnt - 6'd1;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         dividend <= absA;
         divisor  <= {absB, 31'd0};                    // Quotient bit 31 first
         quotient <= '0;
         negate   <= startSign;
         remMode  <= isRem;
      end else if (cnt > 6'd1) begin                   // 32 restoring steps
         divisor <= divisor >> 1;
         if (divisor <= {31'd0, dividend}) begin
            quotient <= {quotient[30:0], 1'b1};
            dividend <= dividend - divisor[31:0];      // Upper bits are zero here
         end else begin
            quotient <= {quotient[30:0], 1'b0};
         end
      end else if (cnt == 6'd1) begin
         // Output cycle, sign fix-up
         // Overflow case gives 0x80000000 and remainder 0 naturally
         if (remMode) begin
            divResult <= negate ? -dividend : dividend;
         end else begin
            divResult <= negate ? -quotient : quotient;
         end
      end
   end

endmodule

`default_nettype wire

/* rtl/execControl.sv */
// One request at a time under four-phase req/ack, reqIn is sampled only when idle
`timescale 1ns/1ps
`default_nettype none

module execControl (
   input  logic             clk,
   input  logic             reset,
   input  logic             req,
   input  execPkg::execReq  reqIn,
   output logic             ack,
   output execPkg::execRsp  rspOut,
   output execPkg::execReq  cur,
   input  logic [31:0]      imm,
   input  logic [31:0]      aluOut,
   input  logic [31:0]      aluSum,
   input  execPkg::aluFlags flags,
   output logic             mulStart,
   input  logic [31:0]      mulResult,
   output logic             divStart,
   input  logic             divBusy,
   input  logic [31:0]      divResult
);

   import rvIsaPkg::*;
   import execPkg::*;

   ctrlState    state;
   logic        curMul;
   logic        curDiv;
   logic        taken;                                 // Branch predicate
   logic        done;                                  // Response can be registered
   logic [31:0] pcPlus4;
   logic [31:0] pcPlusImm;                             // Branch, JAL and AUIPC adder
   logic [31:0] nextPc;
   logic [31:0] result;

   // M-extension class as {div, mul}
   function automatic logic [1:0] mClass(input instrFields i);
      logic isM;
      isM = (i.opcode == OpAluReg) && (i.funct7 == FunctM);
      return {isM & i.funct3[2], isM & ~i.funct3[2]};
   endfunction

   assign {curDiv, curMul} = mClass(cur.instr);

   assign pcPlus4   = cur.pc + 32'd4;
   assign pcPlusImm = cur.pc + imm;

   always_comb begin
      case (cur.instr.funct3)
         F3Beq:   taken = flags.eq;
         F3Bne:   taken = !flags.eq;
         F3Blt:   taken = flags.lt;
         F3Bge:   taken = !flags.lt;
         F3Bltu:  taken = flags.ltu;
         F3Bgeu:  taken = !flags.ltu;
         default: taken = 1'b0;                        // Reserved codes fall through
      endcase
   end

   always_comb begin
      if (cur.instr.opcode == OpJalr) begin
         nextPc = {aluSum[31:1], 1'b0};                // rs1 + I imm, LSB cleared
      end else if ((cur.instr.opcode == OpJal) || ((cur.instr.opcode == OpBranch) && taken)) begin
         nextPc = pcPlusImm;
      end else begin
         nextPc = pcPlus4;
      end
   end

   always_comb begin
      case (cur.instr.opcode)
         OpAluImm:      result = aluOut;
         OpAluReg:      result = curDiv ? divResult : (curMul ? mulResult : aluOut);
         OpLui:         result = imm;                  // U immediate as is
         OpAuipc:       result = pcPlusImm;
         OpJal, OpJalr: result = pcPlus4;              // Link value
         default:       result = '0;                   // Branches and unknown opcodes
      endcase
   end

   // Divider busy only rises after its start cycle, product lands one edge after mulStart
   always_comb begin
      if (curDiv) begin
         done = !divStart && !divBusy;
      end else if (curMul) begin
         done = !mulStart;
      end else begin
         done = 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset) begin
         state    <= Idle;
         ack      <= 1'b0;
         mulStart <= 1'b0;
         divStart <= 1'b0;
      end else begin
         mulStart <= 1'b0;                             // Strobes last one cycle
         divStart <= 1'b0;
         case (state)
            Idle: begin
               if (req) begin
                  state <= Wait;
                  {divStart, mulStart} <= mClass(reqIn.instr);
               end
            end
            Wait: begin
               if (done) begin
                  state <= Hold;
                  ack   <= 1'b1;
               end
            end
            Hold: begin
               if (!req) begin                         // Back-pressure until req drops
                  state <= Idle;
                  ack   <= 1'b0;
               end
            end
            default: state <= Idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if ((state == Idle) && req) begin
         cur <= reqIn;                                 // Held until the next acceptance
      end
      if ((state == Wait) && done) begin
         rspOut.result <= result;
         rspOut.nextPc <= nextPc;
      end
   end

endmodule

`default_nettype wire

/* rtl/rvExecUnit.sv */
// Integer RV32IM execute only, operands arrive with the request and other opcodes return 0 and PC+4
`timescale 1ns/1ps
`default_nettype none

module rvExecUnit (
   input  logic            clk,
   input  logic            reset,
   input  logic            req,
   input  execPkg::execReq reqIn,
   output logic            ack,
   output execPkg::execRsp rspOut
);

   import execPkg::*;

   execReq      cur;                                   // Captured request
   logic [31:0] imm;
   logic [31:0] aluOut;
   logic [31:0] aluSum;
   aluFlags     flags;
   logic        mulStart;
   logic [31:0] mulResult;
   logic        divStart;
   logic        divBusy;
   logic [31:0] divResult;

   execControl execControl_i (
      .clk       (clk),
      .reset     (reset),
      .req       (req),
      .reqIn     (reqIn),
      .ack       (ack),
      .rspOut    (rspOut),
      .cur       (cur),
      .imm       (imm),
      .aluOut    (aluOut),
      .aluSum    (aluSum),
      .flags     (flags),
      .mulStart  (mulStart),
      .mulResult (mulResult),
      .divStart  (divStart),
      .divBusy   (divBusy),
      .divResult (divResult)
   );

   immDecode immDecode_i (
      .instr (cur.instr),
      .imm   (imm)
   );

   intAlu intAlu_i (
      .instr  (cur.instr),
      .rs1Val (cur.rs1Val),
      .rs2Val (cur.rs2Val),
      .imm    (imm),
      .aluOut (aluOut),
      .aluSum (aluSum),
      .flags  (flags)
   );

   mulUnit mulUnit_i (
      .clk       (clk),
      .mulStart  (mulStart),
      .funct3    (cur.instr.funct3),
      .rs1Val    (cur.rs1Val),
      .rs2Val    (cur.rs2Val),
      .mulResult (mulResult)
   );

   divUnit divUnit_i (
      .clk       (clk),
      .reset     (reset),
      .divStart  (divStart),
      .funct3    (cur.instr.funct3),
      .rs1Val    (cur.rs1Val),
      .rs2Val    (cur.rs2Val),
      .divBusy   (divBusy),
      .divResult (divResult)
   );

endmodule

`default_nettype wire

/* verif/rvExecUnit_assert.sv */
// Checks only the four-phase req/ack protocol, response values are left to the testbench
`timescale 1ns/1ps
`default_nettype none

module rvExecUnit_assert (
   input logic            clk,
   input logic            reset,
   input logic            req,
   input logic            ack,
   input execPkg::execRsp rspOut
);

   // ack only answers a pending req
   ackNeedsReq: assert property (@(posedge clk) disable iff (!reset)
      $rose(ack) |-> req)
      else $error("ack rose without req");

   // Release only after the requester let go
   ackDropsAfterReq: assert property (@(posedge clk) disable iff (!reset)
      $fell(ack) |-> !$past(req))
      else $error("ack fell while req was still high");

   // Response held for the whole ack phase
   rspHeld: assert property (@(posedge clk) disable iff (!reset)
      (ack && $past(ack)) |-> $stable(rspOut))
      else $error("rspOut changed while ack was high");

endmodule

`default_nettype wire

/* verif/rvExecUnit_tb.sv */
// Issues one request at a time with a seeded random hold after ack, and fails at the first mismatch
`timescale 1ns/1ps
`default_nettype none

module rvExecUnit_tb;

   import rvIsaPkg::*;
   import execPkg::*;

   localparam int RandN   = 4;                         // Random cases per operation
   localparam int NumReqs = 200;                       // Upper bound on requests issued

   logic            clk;
   logic            reset;
   logic            req;
   execReq          reqIn;
   logic            ack;
   execRsp          rspOut;
   int              seed;
   execRsp          expQ[$];                           // Expected responses in issue order
   string           nameQ[$];
   execRsp          curExp;                            // Response of the request in Hold
   string           curName;
   logic            ackSeen;
   logic [11:0]     imm12;

   // Operand pairs for equal, less and greater, signed and unsigned extremes
   logic [31:0] brRs1 [6] = '{32'd5, 32'hffff_ffff, 32'd1, 32'h8000_0000, 32'h7fff_ffff, 32'd0};
   logic [31:0] brRs2 [6] = '{32'd5, 32'd1, 32'hffff_ffff, 32'h7fff_ffff, 32'h8000_0000,
                              32'hffff_ffff};
   logic [31:0] mulRs1 [4] = '{32'h8000_0000, 32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff};
   logic [31:0] mulRs2 [4] = '{32'h8000_0000, 32'hffff_ffff, 32'hffff_ffff, 32'h8000_0000};
   logic [31:0] divRs1 [3] = '{32'h8000_0000, 32'h1234_5678, 32'd0};   // Overflow, x/0, 0/0
   logic [31:0] divRs2 [3] = '{32'hffff_ffff, 32'd0, 32'd0};

   rvExecUnit rvExecUnit_i (
      .clk    (clk),
      .reset  (reset),
      .req    (req),
      .reqIn  (reqIn),
      .ack    (ack),
      .rspOut (rspOut)
   );

   bind rvExecUnit rvExecUnit_assert protocolCheck_i (
      .clk    (clk),
      .reset  (reset),
      .req    (req),
      .ack    (ack),
      .rspOut (rspOut)
   );

   always #2 clk = ~clk;                               // 4 ns period

   // Instruction encoders, rd = x3, rs1 = x1, rs2 = x2
   function automatic logic [31:0] rType(input logic [6:0] f7, input logic [2:0] f3);
      return {f7, 5'd2, 5'd1, f3, 5'd3, OpAluReg};
   endfunction

   function automatic logic [31:0] iType(input logic [11:0] imm, input logic [2:0] f3,
                                         input logic [6:0] op);
      return {imm, 5'd1, f3, 5'd3, op};
   endfunction

   function automatic logic [31:0] bType(input logic [12:0] imm, input logic [2:0] f3);
      return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], OpBranch};
   endfunction

   function automatic logic [31:0] uType(input logic [19:0] imm, input logic [6:0] op);
      return {imm, 5'd3, op};
   endfunction

   function automatic logic [31:0] jType(input logic [20:0] imm);
      return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd3, OpJal};   // imm[0] not encoded
   endfunction

   // RV32I integer ops, alt is SUB or SRA
   function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
      case (f3)
         F3Add:   return alt ? a - b : a + b;
         F3Sll:   return a << b[4:0];
         F3Slt:   return {31'd0, $signed(a) < $signed(b)};
         F3Sltu:  return {31'd0, a < b};
         F3Xor:   return a ^ b;
         F3Srl: begin
            if (alt) return $signed(a) >>> b[4:0];     // Sign fill
            else return a >> b[4:0];
         end
         F3Or:    return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic logic branchRef(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
      case (f3)
         F3Beq:   return a == b;
         F3Bne:   return a != b;
         F3Blt:   return $signed(a) < $signed(b);
         F3Bge:   return $signed(a) >= $signed(b);
         F3Bltu:  return a < b;
         F3Bgeu:  return a >= b;
         default: return 1'b0;                         // Reserved, never taken
      endcase
   endfunction

   // M extension by the spec, including x/0 and overflow
   function automatic logic [31:0] mulDivRef(input logic [2:0] f3, input logic [31:0] a,
                                             input logic [31:0] b);
      logic [63:0] p;
      int          sa;
      int          sb;
      sa = a;
      sb = b;
      case (f3)
         F3Mulh:   p = {{32{a[31]}}, a} * {{32{b[31]}}, b};   // Low 64 bits of signed product
         F3Mulhsu: p = {{32{a[31]}}, a} * {32'd0, b};
         default:  p = {32'd0, a} * {32'd0, b};
      endcase
      case (f3)
         F3Mul:  return p[31:0];
         F3Div: begin
            if (b == 32'd0) return 32'hffff_ffff;
            else if ((a == 32'h8000_0000) && (b == 32'hffff_ffff)) return a;
            else return sa / sb;
         end
         F3Divu: return (b == 32'd0) ? 32'hffff_ffff : a / b;
         F3Rem: begin
            if (b == 32'd0) return a;
            else if ((a == 32'h8000_0000) && (b == 32'hffff_ffff)) return 32'd0;
            else return sa % sb;
         end
         F3Remu: return (b == 32'd0) ? a : a % b;
         default: return p[63:32];                     // MULH, MULHSU, MULHU
      endcase
   endfunction

   function automatic execRsp refExec(input execReq r);
      logic [31:0] w;
      logic [31:0] iImm;
      logic [31:0] bImm;
      logic [31:0] uImm;
      logic [31:0] jImm;
      execRsp      o;
      w    = r.instr;
      iImm = {{20{w[31]}}, w[31:20]};
      bImm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      uImm = {w[31:12], 12'd0};
      jImm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      o.result = 32'd0;                                // No destination by default
      o.nextPc = r.pc + 32'd4;
      case (w[6:0])
         OpAluImm: o.result = aluRef(w[14:12], w[30] && (w[14:12] == F3Srl), r.rs1Val, iImm);
         OpAluReg: begin
            if (w[31:25] == FunctM) o.result = mulDivRef(w[14:12], r.rs1Val, r.rs2Val);
            else o.result = aluRef(w[14:12], w[30], r.rs1Val, r.rs2Val);
         end
         OpLui:    o.result = uImm;
         OpAuipc:  o.result = r.pc + uImm;
         OpJal: begin
            o.result = r.pc + 32'd4;                   // Link
            o.nextPc = r.pc + jImm;
         end
         OpJalr: begin
            o.result = r.pc + 32'd4;
            o.nextPc = (r.rs1Val + iImm) & ~32'd1;
         end
         OpBranch: if (branchRef(w[14:12], r.rs1Val, r.rs2Val)) o.nextPc = r.pc + bImm;
         default: ;
      endcase
      return o;
   endfunction

   task automatic reportMismatch(input string name);
      $display("Fail %s: expected result=%h nextPc=%h, actual result=%h nextPc=%h",
               name, curExp.result, curExp.nextPc, rspOut.result, rspOut.nextPc);
      $display("Test failed");
      $fatal(1);
   endtask

   // Full four-phase cycle, then reqIn is scrambled while req is held
   task automatic issue(input string name, input logic [31:0] instr, input logic [31:0] a,
                        input logic [31:0] b);
      execReq r;
      int     hold;
      r.pc     = $random(seed) & 32'hffff_fffc;
      r.instr  = instr;
      r.rs1Val = a;
      r.rs2Val = b;
      hold     = {$random(seed)} % 6;
      @(posedge clk);
      req   <= 1'b1;
      reqIn <= r;
      expQ.push_back(refExec(r));
      nameQ.push_back(name);
      do @(posedge clk); while (!ack);
      repeat (hold) begin
         reqIn <= {$random(seed), $random(seed), $random(seed), $random(seed)};
         @(posedge clk);
      end
      req <= 1'b0;
      do @(posedge clk); while (ack);
   endtask

   // Compare on the first cycle of ack, then check the held response
   always @(negedge clk) begin
      if (ack && !ackSeen) begin
         assert (expQ.size() != 0) else begin
            $display("ack rose while no request was outstanding");
            $display("Test failed");
            $fatal(1);
         end
         curExp  = expQ.pop_front();
         curName = nameQ.pop_front();
         assert (rspOut == curExp) else reportMismatch(curName);
      end else if (ack) begin
         assert (rspOut == curExp) else reportMismatch({curName, " held"});
      end
      ackSeen = ack;
   end

   initial begin
      repeat (NumReqs * (DivSteps + 8)) @(posedge clk);
      $display("Timeout: the DUT did not finish all requests in %0d cycles",
               NumReqs * (DivSteps + 8));
      $display("Test failed");
      $fatal(1);
   end

   initial begin
      clk      = 1'b0;
      reset    = 1'b0;                                 // Held for 2 cycles
      req      = 1'b0;
      reqIn    = '0;
      seed     = 32'h8299ab74;
      ackSeen  = 1'b0;
      repeat (2) @(posedge clk);
      reset <= 1'b1;
      for (int k = 0; k < RandN; k++) begin
         for (int f = 0; f < 8; f++) begin
            issue($sformatf("alu reg f3=%0d", f), rType(7'd0, 3'(f)), $random(seed),
                  $random(seed));
         end
         issue("sub", rType(7'h20, F3Add), $random(seed), $random(seed));
         issue("sra", rType(7'h20, F3Srl), $random(seed), $random(seed));
      end
      for (int s = 0; s < 32; s += 31) begin           // Shift by 0 and by 31
         issue("sll edge", rType(7'd0, F3Sll), 32'h8000_0001, 32'(s));
         issue("srl edge", rType(7'd0, F3Srl), 32'h8765_4321, 32'(s));
         issue("sra edge", rType(7'h20, F3Srl), 32'h8765_4321, 32'(s));
         issue("srai edge", iType(12'h400 | 12'(s), F3Srl, OpAluImm), 32'hf000_0000, 32'd0);
      end
      issue("slt mixed", rType(7'd0, F3Slt), 32'hffff_ffff, 32'd1);
      issue("sltu mixed", rType(7'd0, F3Sltu), 32'hffff_ffff, 32'd1);
      issue("slt mixed", rType(7'd0, F3Slt), 32'd1, 32'hffff_ffff);
      issue("sltu mixed", rType(7'd0, F3Sltu), 32'd1, 32'hffff_ffff);
      for (int k = 0; k < RandN; k++) begin
         for (int f = 0; f < 8; f++) begin
            imm12 = 12'($random(seed));
            if (f == 1) imm12 &= 12'h01f;              // SLLI shamt only
            if (f == 5) imm12 &= 12'h41f;              // SRLI or SRAI
            issue($sformatf("alu imm f3=%0d", f), iType(imm12, 3'(f), OpAluImm),
                  $random(seed), 32'd0);
         end
         issue("lui", uType(20'($random(seed)), OpLui), 32'd0, 32'd0);
         issue("auipc", uType(20'($random(seed)), OpAuipc), 32'd0, 32'd0);
         issue("jal", jType(21'($random(seed))), 32'd0, 32'd0);
         issue("jalr", iType(12'($random(seed)), 3'd0, OpJalr), $random(seed), 32'd0);
      end
      issue("jalr odd target", iType(12'h001, 3'd0, OpJalr), 32'h0000_1000, 32'd0);
      for (int f = 0; f < 8; f++) begin
         if ((f != 2) && (f != 3)) begin               // Six valid conditions
            for (int k = 0; k < 6; k++) begin
               issue($sformatf("branch f3=%0d pair %0d", f, k),
                     bType(13'($random(seed)), 3'(f)), brRs1[k], brRs2[k]);
            end
         end
      end
      for (int f = 0; f < 4; f++) begin
         for (int k = 0; k < 4; k++) begin
            issue($sformatf("mul f3=%0d extreme %0d", f, k), rType(FunctM, 3'(f)),
                  mulRs1[k], mulRs2[k]);
            issue($sformatf("mul f3=%0d random", f), rType(FunctM, 3'(f)), $random(seed),
                  $random(seed));
         end
      end
      for (int f = 4; f < 8; f++) begin
         for (int k = 0; k < 3; k++) begin
            issue($sformatf("div f3=%0d special %0d", f, k), rType(FunctM, 3'(f)),
                  divRs1[k], divRs2[k]);
         end
         for (int k = 0; k < 4; k++) begin             // Narrower divisors give larger quotients
            issue($sformatf("div f3=%0d random", f), rType(FunctM, 3'(f)), $random(seed),
                  $random(seed) >> (8 * k));
         end
      end
      issue("unknown opcode", iType(12'h123, 3'd2, 7'b0000011), 32'd5, 32'd6);
      $display("Test passed");
      $finish;
   end

endmodule

`default_nettype wire

/* flist.f */
common/rvIsaPkg.sv
common/execPkg.sv
rtl/immDecode.sv
rtl/intAlu.sv
muldiv/mulUnit.sv
muldiv/divUnit.sv
rtl/execControl.sv
rtl/rvExecUnit.sv
verif/rvExecUnit_assert.sv
verif/rvExecUnit_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module rvExecUnit_tb -f flist.f -o simv || exit 1
out="$(./obj_dir/simv 2>&1)"
echo "$out"
echo "$out" | grep -q "Test passed" && exit 0 || exit 1
